// File: common/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// ##################################################
// Core widths and memory size
`define CPU_DATA_W    8
`define CPU_ADDR_W    8
`define CPU_MEM_DEPTH 256

// ##################################################
// APB debug port and register map
`define APB_ADDR_W   12
`define APB_ROM_BASE 12'h000
`define APB_RAM_BASE 12'h100
`define APB_CTRL     12'h200   // Bit 0 written high starts the CPU.
`define APB_STATUS   12'h201   // Bit 0 is the running bit.
`define APB_REG_A    12'h210
`define APB_REG_B    12'h211
`define APB_REG_X    12'h212
`define APB_REG_Q    12'h213
`define APB_FLAGS    12'h214   // Bit 1 carry, bit 0 zero.
`define APB_PC       12'h215

`endif

// File: common/cpuPkg.sv
`include "cpu_defs.svh"

package cpuPkg;

   // ##################################################
   // Source codes, one per bus driver
   localparam logic [2:0] SRC_ROM  = 3'd0;   // Immediate from ROM[pc].
   localparam logic [2:0] SRC_ZERO = 3'd1;
   localparam logic [2:0] SRC_A    = 3'd2;
   localparam logic [2:0] SRC_B    = 3'd3;
   localparam logic [2:0] SRC_X    = 3'd4;
   localparam logic [2:0] SRC_RAM  = 3'd5;   // RAM[X].
   localparam logic [2:0] SRC_E    = 3'd6;   // A plus or minus B.
   localparam logic [2:0] SRC_S    = 3'd7;   // A shifted left.

   // Destination codes, one per load strobe
   localparam logic [2:0] DST_IR   = 3'd0;   // No-op in execute.
   localparam logic [2:0] DST_PC   = 3'd1;   // Conditional jump.
   localparam logic [2:0] DST_A    = 3'd2;
   localparam logic [2:0] DST_B    = 3'd3;
   localparam logic [2:0] DST_X    = 3'd4;
   localparam logic [2:0] DST_RAM  = 3'd5;
   localparam logic [2:0] DST_Q    = 3'd6;
   localparam logic [2:0] DST_HALT = 3'd7;

   // ##################################################
   // Types
   typedef struct packed {
      logic       carryCond;   // Jump needs carry.
      logic [2:0] dest;
      logic       subZero;     // Subtract, and jump needs zero.
      logic [2:0] source;
   } instrT;

   typedef struct packed {
      logic       loadA;
      logic       loadB;
      logic       loadX;
      logic       loadQ;
      logic       storeMem;
      logic [2:0] busSel;
      logic       triggerC;    // Capture carry and zero.
      logic       doSubtract;
      logic       readRom;     // Immediate consumed, pc moves on.
      logic       halt;
   } busCtrlT;

   typedef struct packed {
      logic carry;
      logic zero;
   } flagsT;

   typedef struct packed {
      logic                   psel;
      logic                   penable;
      logic                   pwrite;
      logic [`APB_ADDR_W-1:0] paddr;
      logic [`CPU_DATA_W-1:0] pwdata;
   } apbReqT;

   typedef struct packed {
      logic [`CPU_DATA_W-1:0] prdata;
      logic                   pready;
      logic                   pslverr;
   } apbRspT;

endpackage

// File: control/controlDecode.sv
module controlDecode (
   input  cpuPkg::instrT   ir,
   input  cpuPkg::flagsT   flags,
   input  logic            phase,
   output cpuPkg::busCtrlT ctrl,
   output logic            jumpTaken
);

   logic [7:0] destHot;
   logic [7:0] srcHot;
   logic       takeForZero;
   logic       takeForCarry;

   // ##################################################
   // Destination and source demultiplexers

   // Both demuxes are enabled only in the execute phase.
   assign destHot = phase ? (8'b1 << ir.dest) : 8'b0;
   assign srcHot  = phase ? (8'b1 << ir.source) : 8'b0;

   always_comb begin
      ctrl.loadA      = destHot[cpuPkg::DST_A];
      ctrl.loadB      = destHot[cpuPkg::DST_B];
      ctrl.loadX      = destHot[cpuPkg::DST_X];
      ctrl.loadQ      = destHot[cpuPkg::DST_Q];
      ctrl.storeMem   = destHot[cpuPkg::DST_RAM];
      ctrl.halt       = destHot[cpuPkg::DST_HALT];
      // IR as a destination loads nothing here.
      ctrl.busSel     = ir.source;
      ctrl.readRom    = srcHot[cpuPkg::SRC_ROM];
      ctrl.triggerC   = srcHot[cpuPkg::SRC_E] | srcHot[cpuPkg::SRC_S];   // ALU or shifter.
      ctrl.doSubtract = ir.subZero;
   end

   // ##################################################
   // Conditional jump

   // Each condition passes when it is not required or its flag is set.
   assign takeForZero  = flags.zero | ~ir.subZero;
   assign takeForCarry = flags.carry | ~ir.carryCond;
   assign jumpTaken    = destHot[cpuPkg::DST_PC] & takeForZero & takeForCarry;

endmodule

// File: datapath/dataPath.sv
`include "cpu_defs.svh"

module dataPath (
   input  logic                   clk,
   input  logic                   arstN,
   input  cpuPkg::busCtrlT        ctrl,
   input  logic [`CPU_DATA_W-1:0] romData,
   input  logic [`CPU_DATA_W-1:0] ramData,
   output logic [`CPU_DATA_W-1:0] bus,
   output cpuPkg::flagsT          flags,
   output logic [`CPU_DATA_W-1:0] regA,
   output logic [`CPU_DATA_W-1:0] regB,
   output logic [`CPU_DATA_W-1:0] regX,
   output logic [`CPU_DATA_W-1:0] regQ
);

   logic [`CPU_DATA_W-1:0] operandB;
   logic [`CPU_DATA_W-1:0] aluOut;
   logic                   aluCarry;
   logic [`CPU_DATA_W-1:0] shiftOut;
   logic                   shiftCarry;

   // ##################################################
   // ALU and shifter

   // Subtract is A + ~B + 1, carry high means no borrow.
   assign operandB = ctrl.doSubtract ? ~regB : regB;
   assign {aluCarry, aluOut} = {1'b0, regA} + {1'b0, operandB}
                             + {{`CPU_DATA_W{1'b0}}, ctrl.doSubtract};

   assign {shiftCarry, shiftOut} = {regA, 1'b0};   // Top bit falls into carry.

   // ##################################################
   // Bus multiplexer

   always_comb begin
      case (ctrl.busSel)
         cpuPkg::SRC_ROM:  bus = romData;
         cpuPkg::SRC_ZERO: bus = '0;
         cpuPkg::SRC_A:    bus = regA;
         cpuPkg::SRC_B:    bus = regB;
         cpuPkg::SRC_X:    bus = regX;
         cpuPkg::SRC_RAM:  bus = ramData;
         cpuPkg::SRC_E:    bus = aluOut;
         cpuPkg::SRC_S:    bus = shiftOut;
         default:          bus = '0;
      endcase
   end

   // ##################################################
   // Registers and flags

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         regA <= '0;
         regB <= '0;
         regX <= '0;
         regQ <= '0;
      end else begin
         if (ctrl.loadA) regA <= bus;
         if (ctrl.loadB) regB <= bus;
         if (ctrl.loadX) regX <= bus;
         if (ctrl.loadQ) regQ <= bus;
      end
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         flags <= '0;
      end else if (ctrl.triggerC) begin
         flags.carry <= (ctrl.busSel == cpuPkg::SRC_S) ? shiftCarry : aluCarry;
         flags.zero  <= (bus == '0);   // Zero of the value on the bus.
      end
   end

endmodule

// File: source/sequencer.sv
`include "cpu_defs.svh"

module sequencer (
   input  logic                   clk,
   input  logic                   arstN,
   input  logic                   runReq,
   input  logic [`CPU_DATA_W-1:0] romData,
   input  logic [`CPU_DATA_W-1:0] bus,
   input  logic                   jumpTaken,
   input  logic                   halt,
   input  logic                   readRom,
   output cpuPkg::instrT          ir,
   output logic [`CPU_ADDR_W-1:0] pc,
   output logic                   phase,
   output logic                   running
);

   localparam logic fetchPhase   = 1'b0;
   localparam logic executePhase = 1'b1;

   // ##################################################
   // Run control and phase

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         running <= 1'b0;
         phase   <= fetchPhase;
      end else if (!running) begin
         phase <= fetchPhase;
         if (runReq) running <= 1'b1;   // First fetch on the next cycle.
      end else if (phase == fetchPhase) begin
         phase <= executePhase;
      end else begin
         phase <= fetchPhase;
         if (halt) running <= 1'b0;
      end
   end

   // ##################################################
   // Program counter and instruction register

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pc <= '0;
         ir <= '0;
      end else if (running) begin
         if (phase == fetchPhase) begin
            ir <= cpuPkg::instrT'(romData);
            pc <= pc + 1'b1;
         end else if (jumpTaken) begin
            pc <= bus;
         end else if (readRom) begin
            pc <= pc + 1'b1;   // Step over the immediate.
         end
      end
   end

endmodule

// File: source/memBank.sv
`include "cpu_defs.svh"

module memBank (
   input  logic                   clk,
   input  logic                   we,
   input  logic [`CPU_ADDR_W-1:0] wAddr,
   input  logic [`CPU_ADDR_W-1:0] rAddr,
   input  logic [`CPU_DATA_W-1:0] wData,
   output logic [`CPU_DATA_W-1:0] rData
);

   logic [`CPU_DATA_W-1:0] mem [`CPU_MEM_DEPTH];

   // Clocked write port.
   always_ff @(posedge clk) begin
      if (we) mem[wAddr] <= wData;
   end

   // Asynchronous read, the bus sees it in the same cycle.
   assign rData = mem[rAddr];

endmodule

// File: source/apbDebug.sv
`include "cpu_defs.svh"

module apbDebug (
   input  logic                   clk,
   input  logic                   arstN,
   input  cpuPkg::apbReqT         apbReq,
   output cpuPkg::apbRspT         apbRsp,
   input  logic                   running,
   input  logic [`CPU_DATA_W-1:0] regA,
   input  logic [`CPU_DATA_W-1:0] regB,
   input  logic [`CPU_DATA_W-1:0] regX,
   input  logic [`CPU_DATA_W-1:0] regQ,
   input  logic [`CPU_ADDR_W-1:0] pc,
   input  cpuPkg::flagsT          flags,
   output logic                   romWe,
   output logic                   ramWe,
   output logic [`CPU_ADDR_W-1:0] memAddr,
   output logic [`CPU_DATA_W-1:0] memData,
   input  logic [`CPU_DATA_W-1:0] romRd,
   input  logic [`CPU_DATA_W-1:0] ramRd,
   output logic                   runReq
);

   localparam logic [`APB_ADDR_W-1:0] romBase = `APB_ROM_BASE;
   localparam logic [`APB_ADDR_W-1:0] ramBase = `APB_RAM_BASE;

   logic                   setupCyc;
   logic                   accessCyc;
   logic                   writeAcc;
   logic                   inRom;
   logic                   inRam;
   logic                   isCtrl;
   logic                   isReadOnly;
   logic                   slvErr;
   logic [`CPU_DATA_W-1:0] rdData;
   logic [`CPU_DATA_W-1:0] rdDataQ;

   // ##################################################
   // Address decode

   assign setupCyc   = apbReq.psel & ~apbReq.penable;
   assign accessCyc  = apbReq.psel & apbReq.penable;
   assign writeAcc   = accessCyc & apbReq.pwrite;
   assign inRom      = apbReq.paddr[`APB_ADDR_W-1:`CPU_ADDR_W] == romBase[`APB_ADDR_W-1:`CPU_ADDR_W];
   assign inRam      = apbReq.paddr[`APB_ADDR_W-1:`CPU_ADDR_W] == ramBase[`APB_ADDR_W-1:`CPU_ADDR_W];
   assign isCtrl     = apbReq.paddr == `APB_CTRL;
   assign isReadOnly = apbReq.paddr inside {`APB_STATUS, `APB_REG_A, `APB_REG_B, `APB_REG_X,
                                            `APB_REG_Q, `APB_FLAGS, `APB_PC};

   // Memory writes only while halted.
   assign romWe   = writeAcc & inRom & ~running;
   assign ramWe   = writeAcc & inRam & ~running;
   assign memAddr = apbReq.paddr[`CPU_ADDR_W-1:0];
   assign memData = apbReq.pwdata;
   assign runReq  = writeAcc & isCtrl & apbReq.pwdata[0] & ~running;

   assign slvErr = (writeAcc & (inRom | inRam) & running)
                 | (writeAcc & isReadOnly)
                 | (accessCyc & ~(inRom | inRam | isCtrl | isReadOnly));

   // ##################################################
   // Readback

   always_comb begin
      if (inRom) begin
         rdData = romRd;
      end else if (inRam) begin
         rdData = ramRd;
      end else begin
         case (apbReq.paddr)
            `APB_CTRL, `APB_STATUS: rdData = {{(`CPU_DATA_W-1){1'b0}}, running};
            `APB_REG_A:             rdData = regA;
            `APB_REG_B:             rdData = regB;
            `APB_REG_X:             rdData = regX;
            `APB_REG_Q:             rdData = regQ;
            `APB_FLAGS:             rdData = {{(`CPU_DATA_W-2){1'b0}}, flags};
            `APB_PC:                rdData = pc;
            default:                rdData = '0;
         endcase
      end
   end

   // Sampled at the end of setup, held through the access cycle.
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) rdDataQ <= '0;
      else if (setupCyc) rdDataQ <= rdData;
   end

   assign apbRsp = '{prdata: rdDataQ, pready: 1'b1, pslverr: slvErr};

endmodule

// File: source/cpuTop.sv
`include "cpu_defs.svh"

module cpuTop (
   input  logic           clk,
   input  logic           arstN,
   input  cpuPkg::apbReqT apbReq,
   output cpuPkg::apbRspT apbRsp
);

   cpuPkg::instrT          ir;
   cpuPkg::flagsT          flags;
   cpuPkg::busCtrlT        ctrl;
   logic [`CPU_ADDR_W-1:0] pc;
   logic [`CPU_DATA_W-1:0] bus;
   logic [`CPU_DATA_W-1:0] regA, regB, regX, regQ;
   logic [`CPU_DATA_W-1:0] romData, ramData;
   logic [`CPU_ADDR_W-1:0] memAddr;
   logic [`CPU_DATA_W-1:0] memData;
   logic [`CPU_ADDR_W-1:0] romRAddr, ramAddr;
   logic [`CPU_DATA_W-1:0] ramWData;
   logic                   phase, running, jumpTaken, runReq;
   logic                   romWe, ramWe, ramWrite;

   // ##################################################
   // Memory port sharing, the debug port owns them while halted
   assign romRAddr = running ? pc : memAddr;
   assign ramAddr  = running ? regX : memAddr;
   assign ramWData = running ? bus : memData;
   assign ramWrite = running ? ctrl.storeMem : ramWe;

   apbDebug apbDebug_i (
      .clk(clk), .arstN(arstN), .apbReq(apbReq), .apbRsp(apbRsp), .running(running),
      .regA(regA), .regB(regB), .regX(regX), .regQ(regQ), .pc(pc), .flags(flags),
      .romWe(romWe), .ramWe(ramWe), .memAddr(memAddr), .memData(memData),
      .romRd(romData), .ramRd(ramData), .runReq(runReq)
   );

   sequencer sequencer_i (
      .clk(clk), .arstN(arstN), .runReq(runReq), .romData(romData), .bus(bus),
      .jumpTaken(jumpTaken), .halt(ctrl.halt), .readRom(ctrl.readRom),
      .ir(ir), .pc(pc), .phase(phase), .running(running)
   );

   controlDecode controlDecode_i (
      .ir(ir), .flags(flags), .phase(phase), .ctrl(ctrl), .jumpTaken(jumpTaken)
   );

   dataPath dataPath_i (
      .clk(clk), .arstN(arstN), .ctrl(ctrl), .romData(romData), .ramData(ramData),
      .bus(bus), .flags(flags), .regA(regA), .regB(regB), .regX(regX), .regQ(regQ)
   );

   memBank romBank_i (
      .clk(clk), .we(romWe), .wAddr(memAddr), .rAddr(romRAddr), .wData(memData),
      .rData(romData)
   );

   memBank ramBank_i (
      .clk(clk), .we(ramWrite), .wAddr(ramAddr), .rAddr(ramAddr), .wData(ramWData),
      .rData(ramData)
   );

endmodule

// File: verification/cpu_chk.sv
`include "cpu_defs.svh"

module cpuChk (
   input logic                   clk,
   input logic                   arstN,
   input cpuPkg::apbReqT         apbReq,
   input cpuPkg::apbRspT         apbRsp,
   input logic                   running,
   input logic                   phase,
   input logic                   jumpTaken,
   input cpuPkg::busCtrlT        ctrl,
   input logic [`CPU_ADDR_W-1:0] pc
);

   int   failCount = 0;
   logic accessCyc;
   logic memWrite;

   assign accessCyc = apbReq.psel & apbReq.penable;
   assign memWrite  = accessCyc & apbReq.pwrite
                    & (apbReq.paddr < (`APB_RAM_BASE + `CPU_MEM_DEPTH));

   // ##################################################
   // APB protocol

   readyHigh: assert property (@(posedge clk) disable iff (!arstN) apbRsp.pready)
      else begin
         failCount++;
         $error("pready dropped low");
      end

   // prdata must not move inside the access window.
   rdataHeld: assert property (@(posedge clk) disable iff (!arstN)
      accessCyc |=> $stable(apbRsp.prdata))
      else begin
         failCount++;
         $error("prdata changed during the access cycle");
      end

   busyWriteErr: assert property (@(posedge clk) disable iff (!arstN)
      memWrite && running |-> apbRsp.pslverr)
      else begin
         failCount++;
         $error("memory write while running gave no pslverr");
      end

   // ##################################################
   // Run and halt

   haltStops: assert property (@(posedge clk) disable iff (!arstN)
      running && phase && ctrl.halt |=> !running)
      else begin
         failCount++;
         $error("running still high after a halt instruction");
      end

   keepRunning: assert property (@(posedge clk) disable iff (!arstN)
      running && !(phase && ctrl.halt) |=> running)
      else begin
         failCount++;
         $error("running fell without a halt instruction");
      end

   pcMoves: assert property (@(posedge clk) disable iff (!arstN)
      pc != $past(pc) |-> $past(running && (!phase || ctrl.readRom || jumpTaken)))
      else begin
         failCount++;
         $error("pc changed outside fetch, immediate or jump");
      end

endmodule

bind cpuTop cpuChk cpuChk_i (
   .clk(clk), .arstN(arstN), .apbReq(apbReq), .apbRsp(apbRsp), .running(running),
   .phase(phase), .jumpTaken(jumpTaken), .ctrl(ctrl), .pc(pc)
);

// File: verification/cpuTb.sv
`include "cpu_defs.svh"

module cpuTb;

   localparam logic [2:0] srcRom  = 3'd0;
   localparam logic [2:0] srcZero = 3'd1;
   localparam logic [2:0] srcX    = 3'd4;
   localparam logic [2:0] srcRam  = 3'd5;
   localparam logic [2:0] srcE    = 3'd6;
   localparam logic [2:0] srcS    = 3'd7;
   localparam logic [2:0] dstPc   = 3'd1;
   localparam logic [2:0] dstA    = 3'd2;
   localparam logic [2:0] dstB    = 3'd3;
   localparam logic [2:0] dstX    = 3'd4;
   localparam logic [2:0] dstRam  = 3'd5;
   localparam logic [2:0] dstQ    = 3'd6;
   localparam logic [2:0] dstHalt = 3'd7;
   localparam int         timeout = 200;

   logic           clk;
   logic           arstN;
   cpuPkg::apbReqT apbReq;
   cpuPkg::apbRspT apbRsp;
   int             seed = 90;
   int             errCount = 0;
   int             timeoutCount = 0;
   int             cycleCnt = 0;
   logic [7:0]     romImage[$];
   logic [7:0]     base;                // Start address of the next program.
   logic [7:0]     opA, opB;
   logic [7:0]     rdVal;
   logic           rdErr;

   cpuTop dut_i (.clk(clk), .arstN(arstN), .apbReq(apbReq), .apbRsp(apbRsp));

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) cycleCnt++;

   function automatic logic [7:0] encode(input logic cc, input logic [2:0] dst,
                                         input logic sz, input logic [2:0] src);
      return {cc, dst, sz, src};
   endfunction

   task automatic checkVal(input string name, input logic [11:0] addr,
                           input logic [7:0] got, input logic [7:0] exp);
      assert (got === exp) else begin
         errCount++;
         $display("ERR %s at %h: got %h, expected %h", name, addr, got, exp);
      end
   endtask

   // ##################################################
   // APB transfers

   task automatic apbXfer(input logic write, input logic [11:0] addr, input logic [7:0] wdata,
                          output logic [7:0] rdata, output logic err);
      int waitCnt;
      waitCnt = 0;
      @(negedge clk);
      apbReq = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
      @(negedge clk);
      apbReq.penable = 1'b1;
      @(negedge clk);
      while (!apbRsp.pready && waitCnt < timeout) begin
         waitCnt++;
         @(negedge clk);
      end
      if (!apbRsp.pready) begin
         timeoutCount++;
         $display("Timeout: pready never came on the access to %h", addr);
      end
      rdata  = apbRsp.prdata;
      err    = apbRsp.pslverr;
      apbReq = '0;
   endtask

   task automatic apbWrite(input logic [11:0] addr, input logic [7:0] data, input logic expErr);
      logic [7:0] unused;
      logic       err;
      apbXfer(1'b1, addr, data, unused, err);
      checkVal("pslverr", addr, {7'b0, err}, {7'b0, expErr});
   endtask

   task automatic readCheck(input string name, input logic [11:0] addr, input logic [7:0] exp);
      logic [7:0] data;
      logic       err;
      apbXfer(1'b0, addr, 8'h00, data, err);
      checkVal(name, addr, data, exp);
      checkVal("pslverr", addr, {7'b0, err}, 8'h00);
   endtask

   // ##################################################
   // Programs

   task automatic runProgram();
      logic [7:0] status;
      logic       err;
      int         startCyc;
      foreach (romImage[i]) apbWrite(`APB_ROM_BASE + {4'h0, base} + 12'(i), romImage[i], 1'b0);
      apbWrite(`APB_CTRL, 8'h01, 1'b0);
      apbWrite(`APB_RAM_BASE + 12'h0A5, 8'hC3, 1'b1);   // The CPU owns RAM while running.
      startCyc = cycleCnt;
      do begin
         apbXfer(1'b0, `APB_STATUS, 8'h00, status, err);
      end while (status[0] && (cycleCnt - startCyc) < timeout);
      if (status[0]) begin
         timeoutCount++;
         $display("Timeout: CPU still running after %0d cycles", timeout);
      end
   endtask

   task automatic aluTest(input logic sub);
      logic [7:0] a;
      logic [7:0] b;
      logic [8:0] res;
      a   = 8'($random(seed));
      b   = 8'($random(seed));
      res = sub ? {a >= b, 8'(a - b)} : {1'b0, a} + {1'b0, b};   // Carry means no borrow.
      romImage = '{encode(1'b0, dstA, 1'b0, srcRom), a, encode(1'b0, dstB, 1'b0, srcRom), b,
                   encode(1'b0, dstQ, sub, srcE), encode(1'b0, dstHalt, 1'b0, srcZero)};
      runProgram();
      readCheck("regQ", `APB_REG_Q, res[7:0]);
      readCheck("flags", `APB_FLAGS, {6'b0, res[8], res[7:0] == 8'h00});
      base = base + 8'd6;
      readCheck("pc", `APB_PC, base);
   endtask

   task automatic jumpTest(input logic useCarry, input logic [7:0] a, input logic [7:0] b);
      logic [8:0] res;
      logic       taken;
      res   = useCarry ? {1'b0, a} + {1'b0, b} : {a >= b, 8'(a - b)};
      taken = useCarry ? res[8] : (res[7:0] == 8'h00);
      romImage = '{encode(1'b0, dstA, 1'b0, srcRom), a, encode(1'b0, dstB, 1'b0, srcRom), b,
                   encode(1'b0, dstQ, !useCarry, srcE),
                   encode(useCarry, dstPc, !useCarry, srcRom), base + 8'd10,
                   encode(1'b0, dstA, 1'b0, srcRom), 8'h11, encode(1'b0, dstHalt, 1'b0, srcZero),
                   encode(1'b0, dstA, 1'b0, srcRom), 8'h22, encode(1'b0, dstHalt, 1'b0, srcZero)};
      runProgram();
      readCheck("regA", `APB_REG_A, taken ? 8'h22 : 8'h11);
      base = base + (taken ? 8'd13 : 8'd10);
      readCheck("pc", `APB_PC, base);
   endtask

   // ##################################################
   // Test sequence

   initial begin
      apbReq = '0;
      arstN  = 1'b0;
      base   = 8'h00;
      repeat (5) @(posedge clk);
      @(negedge clk);
      arstN = 1'b1;

      readCheck("status", `APB_STATUS, 8'h00);
      readCheck("regA", `APB_REG_A, 8'h00);
      readCheck("regB", `APB_REG_B, 8'h00);
      readCheck("regX", `APB_REG_X, 8'h00);
      readCheck("regQ", `APB_REG_Q, 8'h00);
      readCheck("flags", `APB_FLAGS, 8'h00);
      readCheck("pc", `APB_PC, 8'h00);
      for (int i = 0; i < 8; i++) begin
         opA = 8'($random(seed));
         opB = 8'($random(seed));
         apbWrite(`APB_RAM_BASE + {4'h0, opA}, opB, 1'b0);
         readCheck("ram", `APB_RAM_BASE + {4'h0, opA}, opB);
      end
      apbWrite(`APB_RAM_BASE + 12'h0A5, 8'h5A, 1'b0);
      apbWrite(`APB_STATUS, 8'h01, 1'b1);   // Read-only.
      apbXfer(1'b0, 12'h300, 8'h00, rdVal, rdErr);
      checkVal("pslverr", 12'h300, {7'b0, rdErr}, 8'h01);

      aluTest(1'b0);
      aluTest(1'b1);

      // Shift, then X out to RAM[X] and back into B
      opA = 8'($random(seed));
      opB = 8'($random(seed)) & 8'h7F;
      romImage = '{encode(1'b0, dstA, 1'b0, srcRom), opA, encode(1'b0, dstQ, 1'b0, srcS),
                   encode(1'b0, dstX, 1'b0, srcRom), opB, encode(1'b0, dstRam, 1'b0, srcX),
                   encode(1'b0, dstB, 1'b0, srcRam), encode(1'b0, dstHalt, 1'b0, srcZero)};
      runProgram();
      readCheck("regQ", `APB_REG_Q, {opA[6:0], 1'b0});
      readCheck("flags", `APB_FLAGS, {6'b0, opA[7], opA[6:0] == 7'h00});
      readCheck("regB", `APB_REG_B, opB);
      readCheck("ram", `APB_RAM_BASE + {4'h0, opB}, opB);
      base = base + 8'd8;
      readCheck("pc", `APB_PC, base);

      opA = 8'($random(seed));
      jumpTest(1'b0, opA, opA);
      jumpTest(1'b0, opA, opA ^ 8'h01);
      jumpTest(1'b1, opA | 8'h80, 8'h80);
      jumpTest(1'b1, opA & 8'h3F, 8'h40);
      readCheck("ram", `APB_RAM_BASE + 12'h0A5, 8'h5A);

      $display("Errors: %0d value, %0d timeout, %0d assertion",
               errCount, timeoutCount, dut_i.cpuChk_i.failCount);
      if (errCount == 0 && timeoutCount == 0 && dut_i.cpuChk_i.failCount == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// File: list.f
+incdir+common
common/cpuPkg.sv
control/controlDecode.sv
datapath/dataPath.sv
source/sequencer.sv
source/memBank.sv
source/apbDebug.sv
source/cpuTop.sv
verification/cpu_chk.sv
verification/cpuTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = cpuTb
FILELIST  = list.f
OBJDIR    = obj_dir
PASS_MSG  = SIMULATION PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
